//--- cpu_axi_bridge.f
hw/axi_bridge_pkg.sv
hw/fetch_port.sv
hw/data_port.sv
hw/bus_arbiter.sv
hw/cpu_axi_bridge.sv
tb/tb_cpu_axi_bridge.sv

//--- hw/axi_bridge_pkg.sv
package axi_bridge_pkg;

    // Bus geometry, single-beat word transfers only
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int ID_W   = 4;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [ID_W-1:0]   id_t;

    // Default requester IDs
    localparam id_t FETCH_ID = id_t'(0);
    localparam id_t DATA_ID  = id_t'(1);

    typedef enum logic [1:0] {
        F_IDLE,
        F_READ_ADDR,
        F_READ_DATA,
        F_SAVE
    } fetch_state_t;

    typedef enum logic [2:0] {
        D_IDLE,
        D_WRITE_ADDR,
        D_WRITE_DATA,
        D_WRITE_RESP,
        D_READ_ADDR,
        D_READ_DATA,
        D_SAVE
    } data_state_t;

    // Current owner of the shared master port
    typedef enum logic [1:0] {
        ARB_IDLE,
        FETCH_OWNS,
        DATA_OWNS
    } arb_state_t;

endpackage

//--- hw/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter #(
    parameter axi_bridge_pkg::id_t FETCH_ID = axi_bridge_pkg::FETCH_ID,
    parameter axi_bridge_pkg::id_t DATA_ID  = axi_bridge_pkg::DATA_ID
) (
    input  logic                  ACLK,
    input  logic                  ARESETn,
    // Fetch requester
    input  logic                  f_arvalid_i,
    input  axi_bridge_pkg::addr_t f_araddr_i,
    output logic                  f_arready_o,
    output logic                  f_rvalid_o,
    output axi_bridge_pkg::word_t f_rdata_o,
    input  logic                  f_rready_i,
    // Data requester
    input  logic                  d_arvalid_i,
    input  axi_bridge_pkg::addr_t d_araddr_i,
    output logic                  d_arready_o,
    output logic                  d_rvalid_o,
    output axi_bridge_pkg::word_t d_rdata_o,
    input  logic                  d_rready_i,
    input  logic                  d_awvalid_i,
    input  axi_bridge_pkg::addr_t d_awaddr_i,
    output logic                  d_awready_o,
    input  logic                  d_wvalid_i,
    input  axi_bridge_pkg::word_t d_wdata_i,
    input  axi_bridge_pkg::strb_t d_wstrb_i,
    output logic                  d_wready_o,
    output logic                  d_bvalid_o,
    input  logic                  d_bready_i,
    // Shared AXI master port
    output logic                  ARVALID_o,
    output axi_bridge_pkg::id_t   ARID_o,
    output axi_bridge_pkg::addr_t ARADDR_o,
    input  logic                  ARREADY_i,
    input  logic                  RVALID_i,
    input  axi_bridge_pkg::word_t RDATA_i,
    output logic                  RREADY_o,
    output logic                  AWVALID_o,
    output axi_bridge_pkg::id_t   AWID_o,
    output axi_bridge_pkg::addr_t AWADDR_o,
    input  logic                  AWREADY_i,
    output logic                  WVALID_o,
    output axi_bridge_pkg::word_t WDATA_o,
    output axi_bridge_pkg::strb_t WSTRB_o,
    input  logic                  WREADY_i,
    input  logic                  BVALID_i,
    output logic                  BREADY_o
);

    import axi_bridge_pkg::*;

    arb_state_t state_r;
    logic       fetch_owns;
    logic       data_owns;
    logic       txn_done;

    assign fetch_owns = (state_r == FETCH_OWNS);
    assign data_owns  = (state_r == DATA_OWNS);
    // Grant ends on the read data or write response transfer
    assign txn_done   = (RVALID_i && RREADY_o) || (BVALID_i && BREADY_o);

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_r <= ARB_IDLE;
        end else if (state_r == ARB_IDLE) begin
            // Data port wins a tie
            if (d_arvalid_i || d_awvalid_i) begin
                state_r <= DATA_OWNS;
            end else if (f_arvalid_i) begin
                state_r <= FETCH_OWNS;
            end
        end else if (txn_done) begin
            state_r <= ARB_IDLE;
        end
    end

    // Read channels go to whichever port owns the bus
    assign ARVALID_o = (fetch_owns && f_arvalid_i) || (data_owns && d_arvalid_i);
    assign ARID_o    = fetch_owns ? FETCH_ID : DATA_ID;
    assign ARADDR_o  = fetch_owns ? f_araddr_i : d_araddr_i;
    assign RREADY_o  = (fetch_owns && f_rready_i) || (data_owns && d_rready_i);

    assign f_arready_o = fetch_owns && ARREADY_i;
    assign f_rvalid_o  = fetch_owns && RVALID_i;
    assign f_rdata_o   = RDATA_i;
    assign d_arready_o = data_owns && ARREADY_i;
    assign d_rvalid_o  = data_owns && RVALID_i;
    assign d_rdata_o   = RDATA_i;

    // Only the data port writes
    assign AWVALID_o   = data_owns && d_awvalid_i;
    assign AWID_o      = DATA_ID;
    assign AWADDR_o    = d_awaddr_i;
    assign WVALID_o    = data_owns && d_wvalid_i;
    assign WDATA_o     = d_wdata_i;
    assign WSTRB_o     = d_wstrb_i;
    assign BREADY_o    = data_owns && d_bready_i;
    assign d_awready_o = data_owns && AWREADY_i;
    assign d_wready_o  = data_owns && WREADY_i;
    assign d_bvalid_o  = data_owns && BVALID_i;

endmodule

//--- hw/cpu_axi_bridge.sv
`timescale 1ns/1ps

module cpu_axi_bridge #(
    parameter axi_bridge_pkg::id_t FETCH_ID = axi_bridge_pkg::FETCH_ID,
    parameter axi_bridge_pkg::id_t DATA_ID  = axi_bridge_pkg::DATA_ID
) (
    input  logic                  ACLK,
    input  logic                  ARESETn,
    // CPU instruction side
    input  axi_bridge_pkg::addr_t pc_i,
    output axi_bridge_pkg::word_t insn_o,
    output axi_bridge_pkg::addr_t insn_addr_o,
    output logic                  insn_valid_o,
    // CPU data side
    input  logic                  load_i,
    input  logic                  store_i,
    input  axi_bridge_pkg::addr_t addr_i,
    input  axi_bridge_pkg::word_t wdata_i,
    input  axi_bridge_pkg::strb_t web_i,
    output axi_bridge_pkg::word_t rd_data_o,
    output axi_bridge_pkg::addr_t rd_addr_o,
    output logic                  rd_valid_o,
    output axi_bridge_pkg::addr_t wr_addr_o,
    output axi_bridge_pkg::word_t wr_data_o,
    output logic                  wr_valid_o,
    // AXI master port
    output logic                  ARVALID_o,
    output axi_bridge_pkg::id_t   ARID_o,
    output axi_bridge_pkg::addr_t ARADDR_o,
    input  logic                  ARREADY_i,
    input  logic                  RVALID_i,
    input  axi_bridge_pkg::word_t RDATA_i,
    output logic                  RREADY_o,
    output logic                  AWVALID_o,
    output axi_bridge_pkg::id_t   AWID_o,
    output axi_bridge_pkg::addr_t AWADDR_o,
    input  logic                  AWREADY_i,
    output logic                  WVALID_o,
    output axi_bridge_pkg::word_t WDATA_o,
    output axi_bridge_pkg::strb_t WSTRB_o,
    input  logic                  WREADY_i,
    input  logic                  BVALID_i,
    output logic                  BREADY_o
);

    import axi_bridge_pkg::*;

    // Fetch port to arbiter
    logic  f_arvalid;
    addr_t f_araddr;
    logic  f_arready;
    logic  f_rvalid;
    word_t f_rdata;
    logic  f_rready;

    // Data port to arbiter
    logic  d_arvalid;
    addr_t d_araddr;
    logic  d_arready;
    logic  d_rvalid;
    word_t d_rdata;
    logic  d_rready;
    logic  d_awvalid;
    addr_t d_awaddr;
    logic  d_awready;
    logic  d_wvalid;
    word_t d_wdata;
    strb_t d_wstrb;
    logic  d_wready;
    logic  d_bvalid;
    logic  d_bready;

    fetch_port i_fetch_port (
        .ACLK         (ACLK),
        .ARESETn      (ARESETn),
        .pc_i         (pc_i),
        .insn_o       (insn_o),
        .insn_addr_o  (insn_addr_o),
        .insn_valid_o (insn_valid_o),
        .arvalid_o    (f_arvalid),
        .araddr_o     (f_araddr),
        .arready_i    (f_arready),
        .rvalid_i     (f_rvalid),
        .rdata_i      (f_rdata),
        .rready_o     (f_rready)
    );

    data_port i_data_port (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .load_i     (load_i),
        .store_i    (store_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .web_i      (web_i),
        .rd_data_o  (rd_data_o),
        .rd_addr_o  (rd_addr_o),
        .rd_valid_o (rd_valid_o),
        .wr_addr_o  (wr_addr_o),
        .wr_data_o  (wr_data_o),
        .wr_valid_o (wr_valid_o),
        .arvalid_o  (d_arvalid),
        .araddr_o   (d_araddr),
        .arready_i  (d_arready),
        .rvalid_i   (d_rvalid),
        .rdata_i    (d_rdata),
        .rready_o   (d_rready),
        .awvalid_o  (d_awvalid),
        .awaddr_o   (d_awaddr),
        .awready_i  (d_awready),
        .wvalid_o   (d_wvalid),
        .wdata_o    (d_wdata),
        .wstrb_o    (d_wstrb),
        .wready_i   (d_wready),
        .bvalid_i   (d_bvalid),
        .bready_o   (d_bready)
    );

    bus_arbiter #(
        .FETCH_ID (FETCH_ID),
        .DATA_ID  (DATA_ID)
    ) i_bus_arbiter (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .f_arvalid_i (f_arvalid),
        .f_araddr_i  (f_araddr),
        .f_arready_o (f_arready),
        .f_rvalid_o  (f_rvalid),
        .f_rdata_o   (f_rdata),
        .f_rready_i  (f_rready),
        .d_arvalid_i (d_arvalid),
        .d_araddr_i  (d_araddr),
        .d_arready_o (d_arready),
        .d_rvalid_o  (d_rvalid),
        .d_rdata_o   (d_rdata),
        .d_rready_i  (d_rready),
        .d_awvalid_i (d_awvalid),
        .d_awaddr_i  (d_awaddr),
        .d_awready_o (d_awready),
        .d_wvalid_i  (d_wvalid),
        .d_wdata_i   (d_wdata),
        .d_wstrb_i   (d_wstrb),
        .d_wready_o  (d_wready),
        .d_bvalid_o  (d_bvalid),
        .d_bready_i  (d_bready),
        .ARVALID_o   (ARVALID_o),
        .ARID_o      (ARID_o),
        .ARADDR_o    (ARADDR_o),
        .ARREADY_i   (ARREADY_i),
        .RVALID_i    (RVALID_i),
        .RDATA_i     (RDATA_i),
        .RREADY_o    (RREADY_o),
        .AWVALID_o   (AWVALID_o),
        .AWID_o      (AWID_o),
        .AWADDR_o    (AWADDR_o),
        .AWREADY_i   (AWREADY_i),
        .WVALID_o    (WVALID_o),
        .WDATA_o     (WDATA_o),
        .WSTRB_o     (WSTRB_o),
        .WREADY_i    (WREADY_i),
        .BVALID_i    (BVALID_i),
        .BREADY_o    (BREADY_o)
    );

endmodule

//--- hw/data_port.sv
`timescale 1ns/1ps

module data_port (
    input  logic                  ACLK,
    input  logic                  ARESETn,
    input  logic                  load_i,
    input  logic                  store_i,
    input  axi_bridge_pkg::addr_t addr_i,
    input  axi_bridge_pkg::word_t wdata_i,
    input  axi_bridge_pkg::strb_t web_i,
    output axi_bridge_pkg::word_t rd_data_o,
    output axi_bridge_pkg::addr_t rd_addr_o,
    output logic                  rd_valid_o,
    output axi_bridge_pkg::addr_t wr_addr_o,
    output axi_bridge_pkg::word_t wr_data_o,
    output logic                  wr_valid_o,
    // AR channel
    output logic                  arvalid_o,
    output axi_bridge_pkg::addr_t araddr_o,
    input  logic                  arready_i,
    // R channel
    input  logic                  rvalid_i,
    input  axi_bridge_pkg::word_t rdata_i,
    output logic                  rready_o,
    // AW channel
    output logic                  awvalid_o,
    output axi_bridge_pkg::addr_t awaddr_o,
    input  logic                  awready_i,
    // W channel
    output logic                  wvalid_o,
    output axi_bridge_pkg::word_t wdata_o,
    output axi_bridge_pkg::strb_t wstrb_o,
    input  logic                  wready_i,
    // B channel
    input  logic                  bvalid_i,
    output logic                  bready_o
);

    import axi_bridge_pkg::*;

    data_state_t state_r;
    data_state_t state_nxt;
    addr_t       addr_r;
    word_t       wdata_r;
    strb_t       wstrb_r;
    word_t       rd_data_r;
    addr_t       rd_addr_r;
    logic        rd_valid_r;
    addr_t       wr_addr_r;
    word_t       wr_data_r;
    logic        wr_valid_r;
    logic        new_store;
    logic        new_load;

    // A request already completed is not issued again
    assign new_store = store_i &&
                       (!wr_valid_r || (wr_addr_r != addr_i) || (wr_data_r != wdata_i));
    assign new_load  = load_i && (!rd_valid_r || (rd_addr_r != addr_i));

    always_comb begin
        state_nxt = state_r;
        case (state_r)
            D_IDLE: begin
                if (new_store) begin
                    state_nxt = D_WRITE_ADDR;
                end else if (new_load) begin
                    state_nxt = D_READ_ADDR;
                end
            end
            D_WRITE_ADDR: begin
                if (awvalid_o && awready_i) begin
                    state_nxt = D_WRITE_DATA;
                end
            end
            D_WRITE_DATA: begin
                if (wvalid_o && wready_i) begin
                    state_nxt = D_WRITE_RESP;
                end
            end
            D_WRITE_RESP: begin
                if (bvalid_i && bready_o) begin
                    state_nxt = D_IDLE;
                end
            end
            D_READ_ADDR: begin
                if (arvalid_o && arready_i) begin
                    state_nxt = D_READ_DATA;
                end
            end
            D_READ_DATA: begin
                if (rvalid_i && rready_o) begin
                    state_nxt = D_SAVE;
                end
            end
            default: begin
                state_nxt = D_IDLE;
            end
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_r    <= D_IDLE;
            rd_valid_r <= 1'b0;
            wr_valid_r <= 1'b0;
        end else begin
            state_r <= state_nxt;
            if (bvalid_i && bready_o) begin
                wr_valid_r <= 1'b1;
                // Held load may now be stale
                rd_valid_r <= 1'b0;
            end else if (rvalid_i && rready_o) begin
                rd_valid_r <= 1'b1;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (state_r == D_IDLE) begin
            addr_r  <= addr_i;
            wdata_r <= wdata_i;
            wstrb_r <= ~web_i;
        end
        if (bvalid_i && bready_o) begin
            wr_addr_r <= addr_r;
            wr_data_r <= wdata_r;
        end
        if (rvalid_i && rready_o) begin
            rd_data_r <= rdata_i;
            rd_addr_r <= addr_r;
        end
    end

    assign arvalid_o  = (state_r == D_READ_ADDR);
    assign araddr_o   = addr_r;
    assign rready_o   = (state_r == D_READ_DATA);
    assign awvalid_o  = (state_r == D_WRITE_ADDR);
    assign awaddr_o   = addr_r;
    assign wvalid_o   = (state_r == D_WRITE_DATA);
    assign wdata_o    = wdata_r;
    assign wstrb_o    = wstrb_r;
    assign bready_o   = (state_r == D_WRITE_RESP);
    assign rd_data_o  = rd_data_r;
    assign rd_addr_o  = rd_addr_r;
    assign rd_valid_o = rd_valid_r;
    assign wr_addr_o  = wr_addr_r;
    assign wr_data_o  = wr_data_r;
    assign wr_valid_o = wr_valid_r;

endmodule

//--- hw/fetch_port.sv
`timescale 1ns/1ps

module fetch_port (
    input  logic                  ACLK,
    input  logic                  ARESETn,
    input  axi_bridge_pkg::addr_t pc_i,
    output axi_bridge_pkg::word_t insn_o,
    output axi_bridge_pkg::addr_t insn_addr_o,
    output logic                  insn_valid_o,
    // AR channel
    output logic                  arvalid_o,
    output axi_bridge_pkg::addr_t araddr_o,
    input  logic                  arready_i,
    // R channel
    input  logic                  rvalid_i,
    input  axi_bridge_pkg::word_t rdata_i,
    output logic                  rready_o
);

    import axi_bridge_pkg::*;

    fetch_state_t state_r;
    fetch_state_t state_nxt;
    addr_t        araddr_r;
    word_t        insn_r;
    addr_t        insn_addr_r;
    logic         insn_valid_r;
    logic         ar_done;
    logic         r_done;

    assign ar_done = arvalid_o && arready_i;
    assign r_done  = rvalid_i && rready_o;

    always_comb begin
        state_nxt = state_r;
        case (state_r)
            F_IDLE: begin
                // Fetch only when the PC moved or nothing is held yet
                if (!insn_valid_r || (insn_addr_r != pc_i)) begin
                    state_nxt = F_READ_ADDR;
                end
            end
            F_READ_ADDR: begin
                if (ar_done) begin
                    state_nxt = F_READ_DATA;
                end
            end
            F_READ_DATA: begin
                if (r_done) begin
                    state_nxt = F_SAVE;
                end
            end
            default: begin
                state_nxt = F_IDLE;
            end
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_r      <= F_IDLE;
            insn_valid_r <= 1'b0;
        end else begin
            state_r <= state_nxt;
            if (r_done) begin
                insn_valid_r <= 1'b1;
            end
        end
    end

    // PC tracked while idle, frozen once the read starts
    always_ff @(posedge ACLK) begin
        if (state_r == F_IDLE) begin
            araddr_r <= pc_i;
        end
        if (r_done) begin
            insn_r      <= rdata_i;
            insn_addr_r <= araddr_r;
        end
    end

    assign arvalid_o    = (state_r == F_READ_ADDR);
    assign araddr_o     = araddr_r;
    assign rready_o     = (state_r == F_READ_DATA);
    assign insn_o       = insn_r;
    assign insn_addr_o  = insn_addr_r;
    assign insn_valid_o = insn_valid_r;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    --top-module tb_cpu_axi_bridge \
    -f cpu_axi_bridge.f \
    -o sim_tb_cpu_axi_bridge
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb_cpu_axi_bridge 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification passed" <<< "$output"; then
    exit 0
else
    exit 1
fi

//--- tb/bridge_input.txt
# op pc addr wdata web exp_insn exp_rd_data exp_strb exp_first_id  (hex, op F L S B)
# memory word at A starts as A ^ A5A50000, stores merge by strobe
F 00000100 00000000 00000000 0 A5A50100 00000000 0 0
F 00000104 00000000 00000000 0 A5A50104 00000000 0 0
F 00000104 00000000 00000000 0 A5A50104 00000000 0 0
L 00000104 00002000 00000000 0 00000000 A5A52000 0 1
L 00000104 00002004 00000000 0 00000000 A5A52004 0 1
S 00000104 00002000 11223344 0 00000000 00000000 F 1
L 00000104 00002000 00000000 0 00000000 11223344 0 1
S 00000104 00002004 DEADBEEF C 00000000 00000000 3 1
L 00000104 00002004 00000000 0 00000000 A5A5BEEF 0 1
S 00000104 00002000 AABBCCDD A 00000000 00000000 5 1
L 00000104 00002000 00000000 0 00000000 11BB33DD 0 1
B 00000108 00002004 00000000 0 A5A50108 A5A5BEEF 0 1
B 0000010C 00003000 00000000 0 A5A5010C A5A53000 0 1
S 0000010C 00003000 01020304 E 00000000 00000000 1 1
B 00000110 00003000 00000000 0 A5A50110 A5A53004 0 1
F 00000200 00000000 00000000 0 A5A50200 00000000 0 0
S 00000200 00000200 CAFEF00D 0 00000000 00000000 F 1
F 00000204 00000000 00000000 0 A5A50204 00000000 0 0
F 00000200 00000000 00000000 0 CAFEF00D 00000000 0 0
L 00000200 00000204 00000000 0 00000000 A5A50204 0 1
S 00000200 00002008 55667788 7 00000000 00000000 8 1
L 00000200 00002008 00000000 0 00000000 55A52008 0 1
B 00000208 00002000 00000000 0 A5A50208 11BB33DD 0 1
S 00000208 0000200C 0F0F0F0F 9 00000000 00000000 6 1
L 00000208 0000200C 00000000 0 00000000 A50F0F0C 0 1
F 0000020C 00000000 00000000 0 A5A5020C 00000000 0 0
L 0000020C 00002008 00000000 0 00000000 55A52008 0 1
S 0000020C 00002010 12345678 0 00000000 00000000 F 1
B 00000210 00002010 00000000 0 A5A50210 12345678 0 1
F 00000210 00000000 00000000 0 A5A50210 00000000 0 0

//--- tb/tb_cpu_axi_bridge.sv
`timescale 1ns/1ps

module tb_cpu_axi_bridge;

    import axi_bridge_pkg::*;

    localparam id_t T_FETCH_ID = id_t'(0);
    localparam id_t T_DATA_ID  = id_t'(1);
    localparam int  MAX_REC    = 64;

    logic  ACLK;
    logic  ARESETn;
    addr_t pc_i;
    word_t insn_o;
    addr_t insn_addr_o;
    logic  insn_valid_o;
    logic  load_i;
    logic  store_i;
    addr_t addr_i;
    word_t wdata_i;
    strb_t web_i;
    word_t rd_data_o;
    addr_t rd_addr_o;
    logic  rd_valid_o;
    addr_t wr_addr_o;
    word_t wr_data_o;
    logic  wr_valid_o;
    logic  ARVALID_o;
    id_t   ARID_o;
    addr_t ARADDR_o;
    logic  ARREADY_i;
    logic  RVALID_i;
    word_t RDATA_i;
    logic  RREADY_o;
    logic  AWVALID_o;
    id_t   AWID_o;
    addr_t AWADDR_o;
    logic  AWREADY_i;
    logic  WVALID_o;
    word_t WDATA_o;
    strb_t WSTRB_o;
    logic  WREADY_i;
    logic  BVALID_i;
    logic  BREADY_o;

    // Records from the data file
    logic [7:0] rec_op   [MAX_REC];
    addr_t      rec_pc   [MAX_REC];
    addr_t      rec_addr [MAX_REC];
    word_t      rec_wdata[MAX_REC];
    strb_t      rec_web  [MAX_REC];
    word_t      rec_insn [MAX_REC];
    word_t      rec_rd   [MAX_REC];
    strb_t      rec_strb [MAX_REC];
    id_t        rec_id   [MAX_REC];
    int         rec_count = 0;

    int          errors = 0;
    int          checks = 0;
    logic [15:0] lfsr_q = 16'd34;
    word_t       mem [addr_t];
    id_t         id_seen[$];
    addr_t       last_pc;
    addr_t       obs_awaddr;
    word_t       obs_wdata;
    strb_t       obs_wstrb;
    logic        ar_pend;
    logic        aw_pend;
    logic        w_pend;
    addr_t       prev_araddr;
    id_t         prev_arid;
    addr_t       prev_awaddr;
    word_t       prev_wdata;
    strb_t       prev_wstrb;

    cpu_axi_bridge #(
        .FETCH_ID (T_FETCH_ID),
        .DATA_ID  (T_DATA_ID)
    ) i_dut (.*);

    initial begin
        ACLK = 1'b0;
        forever #50 ACLK = ~ACLK;
    end

    function automatic logic next_lfsr_bit();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    // 0 to 3 cycles
    function automatic int rand_delay();
        logic b1;
        logic b0;
        b1 = next_lfsr_bit();
        b0 = next_lfsr_bit();
        return {30'd0, b1, b0};
    endfunction

    function automatic word_t mem_read(input addr_t a);
        addr_t wa;
        wa = {a[ADDR_W-1:2], 2'b00};
        if (mem.exists(wa)) begin
            return mem[wa];
        end
        return wa ^ 32'hA5A5_0000;
    endfunction

    task automatic mem_write(input addr_t a, input word_t d, input strb_t s);
        addr_t wa;
        word_t w;
        int    i;
        wa = {a[ADDR_W-1:2], 2'b00};
        w  = mem_read(a);
        for (i = 0; i < STRB_W; i++) begin
            if (s[i]) begin
                w[8*i +: 8] = d[8*i +: 8];
            end
        end
        mem[wa] = w;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge ACLK);
            #10;
        end
    endtask

    // Read slave, one transaction at a time
    initial begin
        addr_t raddr;
        ARREADY_i = 1'b0;
        RVALID_i  = 1'b0;
        RDATA_i   = '0;
        forever begin
            @(negedge ACLK);
            if (ARVALID_o) begin
                raddr = ARADDR_o;
                wait_cycles(rand_delay() + 1);
                ARREADY_i = 1'b1;
                wait_cycles(1);
                ARREADY_i = 1'b0;
                wait_cycles(rand_delay());
                RVALID_i = 1'b1;
                RDATA_i  = mem_read(raddr);
                @(negedge ACLK);
                while (!RREADY_o) @(negedge ACLK);
                @(posedge ACLK);
                #10 RVALID_i = 1'b0;
            end
        end
    end

    // Write slave
    initial begin
        addr_t waddr;
        AWREADY_i = 1'b0;
        WREADY_i  = 1'b0;
        BVALID_i  = 1'b0;
        forever begin
            @(negedge ACLK);
            if (AWVALID_o) begin
                waddr = AWADDR_o;
                wait_cycles(rand_delay() + 1);
                AWREADY_i = 1'b1;
                wait_cycles(1);
                AWREADY_i = 1'b0;
                @(negedge ACLK);
                while (!WVALID_o) @(negedge ACLK);
                mem_write(waddr, WDATA_o, WSTRB_o);
                wait_cycles(rand_delay() + 1);
                WREADY_i = 1'b1;
                wait_cycles(1);
                WREADY_i = 1'b0;
                wait_cycles(rand_delay());
                BVALID_i = 1'b1;
                @(negedge ACLK);
                while (!BREADY_o) @(negedge ACLK);
                @(posedge ACLK);
                #10 BVALID_i = 1'b0;
            end
        end
    end

    // Bus monitor, sampled mid-cycle where everything has settled
    always @(negedge ACLK) begin
        if (ARESETn) begin
            if (ar_pend && (!ARVALID_o || ARADDR_o != prev_araddr || ARID_o != prev_arid)) begin
                $display("AR payload changed or valid dropped before ready");
                errors++;
            end
            if (aw_pend && (!AWVALID_o || AWADDR_o != prev_awaddr)) begin
                $display("AW payload changed or valid dropped before ready");
                errors++;
            end
            if (w_pend && (!WVALID_o || WDATA_o != prev_wdata || WSTRB_o != prev_wstrb)) begin
                $display("W payload changed or valid dropped before ready");
                errors++;
            end
            if (ARVALID_o && ARREADY_i) begin
                id_seen.push_back(ARID_o);
            end
            if (AWVALID_o && AWREADY_i) begin
                id_seen.push_back(AWID_o);
                obs_awaddr = AWADDR_o;
            end
            if (WVALID_o && WREADY_i) begin
                obs_wdata = WDATA_o;
                obs_wstrb = WSTRB_o;
            end
        end
        ar_pend     = ARESETn && ARVALID_o && !ARREADY_i;
        aw_pend     = ARESETn && AWVALID_o && !AWREADY_i;
        w_pend      = ARESETn && WVALID_o && !WREADY_i;
        prev_araddr = ARADDR_o;
        prev_arid   = ARID_o;
        prev_awaddr = AWADDR_o;
        prev_wdata  = WDATA_o;
        prev_wstrb  = WSTRB_o;
    end

    task automatic check_word(input string name, input word_t exp, input word_t got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("Error: %s expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("Error: %s expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic check_strb(input string name, input strb_t exp, input strb_t got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("Error: %s expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic check_id(input string name, input id_t exp, input id_t got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("Error: %s expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("Error: %s expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic check_reset_outputs();
        check_bit("ARVALID_o", 1'b0, ARVALID_o);
        check_bit("AWVALID_o", 1'b0, AWVALID_o);
        check_bit("WVALID_o", 1'b0, WVALID_o);
        check_bit("RREADY_o", 1'b0, RREADY_o);
        check_bit("BREADY_o", 1'b0, BREADY_o);
        check_bit("insn_valid_o", 1'b0, insn_valid_o);
        check_bit("rd_valid_o", 1'b0, rd_valid_o);
        check_bit("wr_valid_o", 1'b0, wr_valid_o);
    endtask

    task automatic load_records();
        int         fd;
        int         n;
        string      line;
        logic [7:0] op;
        addr_t      pc;
        addr_t      ad;
        word_t      wd;
        strb_t      wb;
        word_t      ei;
        word_t      ed;
        strb_t      es;
        id_t        eid;
        fd = $fopen("tb/bridge_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tb/bridge_input.txt");
            errors++;
        end else begin
            while (!$feof(fd) && rec_count < MAX_REC) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() < 2 || line.substr(0, 0) == "#") continue;
                n = $sscanf(line, "%c %h %h %h %h %h %h %h %h",
                            op, pc, ad, wd, wb, ei, ed, es, eid);
                if (n == 9) begin
                    rec_op[rec_count]    = op;
                    rec_pc[rec_count]    = pc;
                    rec_addr[rec_count]  = ad;
                    rec_wdata[rec_count] = wd;
                    rec_web[rec_count]   = wb;
                    rec_insn[rec_count]  = ei;
                    rec_rd[rec_count]    = ed;
                    rec_strb[rec_count]  = es;
                    rec_id[rec_count]    = eid;
                    rec_count++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_record(input int idx);
        logic [7:0] op;
        int         errs_before;
        int         exp_txn;
        logic       f_done;
        logic       d_done;
        op          = rec_op[idx];
        errs_before = errors;
        exp_txn     = (op == "F") ? 0 : 1;
        id_seen.delete();
        if (op == "F" || op == "B") begin
            // Same PC as last time means no new read
            if (rec_pc[idx] != last_pc) exp_txn++;
            last_pc = rec_pc[idx];
            pc_i    = rec_pc[idx];
        end
        addr_i = rec_addr[idx];
        if (op == "L" || op == "B") load_i = 1'b1;
        if (op == "S") begin
            wdata_i = rec_wdata[idx];
            web_i   = rec_web[idx];
            store_i = 1'b1;
        end
        f_done = !(op == "F" || op == "B");
        d_done = (op == "F");
        while (!(f_done && d_done)) begin
            @(negedge ACLK);
            if (!f_done) f_done = insn_valid_o && (insn_addr_o == rec_pc[idx]);
            if (!d_done && op == "S") begin
                d_done = wr_valid_o && (wr_addr_o == rec_addr[idx]) &&
                         (wr_data_o == rec_wdata[idx]);
            end else if (!d_done) begin
                d_done = rd_valid_o && (rd_addr_o == rec_addr[idx]);
            end
        end
        @(posedge ACLK);
        #10;
        load_i  = 1'b0;
        store_i = 1'b0;
        // A few quiet cycles to catch any repeated request
        wait_cycles(4);
        @(negedge ACLK);
        if (op == "F" || op == "B") begin
            check_word("insn_o", rec_insn[idx], insn_o);
            check_addr("insn_addr_o", rec_pc[idx], insn_addr_o);
        end
        if (op == "L" || op == "B") begin
            check_word("rd_data_o", rec_rd[idx], rd_data_o);
            check_addr("rd_addr_o", rec_addr[idx], rd_addr_o);
        end
        if (op == "S") begin
            check_addr("AWADDR_o", rec_addr[idx], obs_awaddr);
            check_word("WDATA_o", rec_wdata[idx], obs_wdata);
            check_strb("WSTRB_o", rec_strb[idx], obs_wstrb);
            check_addr("wr_addr_o", rec_addr[idx], wr_addr_o);
            check_word("wr_data_o", rec_wdata[idx], wr_data_o);
            check_bit("rd_valid_o", 1'b0, rd_valid_o);
        end
        checks++;
        if (id_seen.size() != exp_txn) begin
            errors++;
            $display("Expected %0d bus transfers but saw %0d", exp_txn, id_seen.size());
        end else if (exp_txn > 0) begin
            check_id("first ID", rec_id[idx], id_seen[0]);
            if (exp_txn > 1) check_id("second ID", T_FETCH_ID, id_seen[1]);
        end
        $display("record %0d op %c: %s", idx, op, (errors == errs_before) ? "ok" : "FAILED");
        @(posedge ACLK);
        #10;
    endtask

    initial begin
        int i;
        ARESETn = 1'b0;
        pc_i    = '0;
        load_i  = 1'b0;
        store_i = 1'b0;
        addr_i  = '0;
        wdata_i = '0;
        web_i   = '0;
        last_pc = '0;
        load_records();
        @(negedge ACLK);
        check_reset_outputs();
        repeat (2) @(posedge ACLK);
        #10 ARESETn = 1'b1;
        @(negedge ACLK);
        check_reset_outputs();
        // The fetch port reads PC 0 on its own after reset
        while (!(insn_valid_o && insn_addr_o == '0)) @(negedge ACLK);
        check_word("insn_o", 32'hA5A5_0000, insn_o);
        @(posedge ACLK);
        #10;
        if (rec_count == 0) begin
            $display("No records found in the data file");
            errors++;
        end
        for (i = 0; i < rec_count; i++) begin
            run_record(i);
        end
        $display("%0d records, %0d checks, %0d errors", rec_count, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        @(posedge ARESETn);
        repeat ((rec_count + 1) * 64) @(posedge ACLK);
        $display("Timeout: the records did not complete in the allowed time");
        $display("Verification failed");
        $finish;
    end

endmodule
